/* all.f */
+incdir+bench
source/ex_isa_pkg.sv
source/ex_pipe_pkg.sv
source/ex_skid_reg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_exec.sv
source/ex_stage_top.sv
bench/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - source/ex_isa_pkg.sv
      - source/ex_pipe_pkg.sv
      - source/ex_skid_reg.sv
      - source/ex_alu.sv
      - source/ex_mult.sv
      - source/ex_exec.sv
      - source/ex_stage_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ex_stage_tb.sv

/* bench/ex_stage_vectors.svh */
// Operation table with expected writeback records, included by the execute stage testbench
`ifndef EX_STAGE_VECTORS_SVH
`define EX_STAGE_VECTORS_SVH

localparam int NUM_VEC      = 33;
// Entries reused by the latency checks
localparam int ALU_LAT_IDX  = 0;
localparam int MULH_LAT_IDX = 28;

ex_pipe_pkg::issue_t vec_issue [NUM_VEC];
ex_pipe_pkg::wb_t    vec_wb    [NUM_VEC];

task automatic load_vectors();
  // Arithmetic and logic, with wrap around
  add_alu(ex_isa_pkg::ALU_ADD,  32'h0000_0005, 32'h0000_0003, 5'd1,  1'b1, 32'h0000_0008);
  add_alu(ex_isa_pkg::ALU_ADD,  32'h7FFF_FFFF, 32'h0000_0001, 5'd2,  1'b1, 32'h8000_0000);
  add_alu(ex_isa_pkg::ALU_ADD,  32'hFFFF_FFFF, 32'h0000_0002, 5'd3,  1'b1, 32'h0000_0001);
  add_alu(ex_isa_pkg::ALU_SUB,  32'h0000_0003, 32'h0000_0005, 5'd4,  1'b1, 32'hFFFF_FFFE);
  add_alu(ex_isa_pkg::ALU_AND,  32'hF0F0_F0F0, 32'h0FF0_0FF0, 5'd5,  1'b1, 32'h00F0_00F0);
  // Write enable low still carries address and data
  add_alu(ex_isa_pkg::ALU_OR,   32'hF0F0_F0F0, 32'h0FF0_0FF0, 5'd6,  1'b0, 32'hFFF0_FFF0);
  add_alu(ex_isa_pkg::ALU_XOR,  32'hF0F0_F0F0, 32'h0FF0_0FF0, 5'd7,  1'b1, 32'hFF00_FF00);
  // Shifts by 0, 1 and 31, upper bits of operand b ignored
  add_alu(ex_isa_pkg::ALU_SLL,  32'h8000_0001, 32'h0000_0000, 5'd8,  1'b1, 32'h8000_0001);
  add_alu(ex_isa_pkg::ALU_SLL,  32'h8000_0001, 32'h0000_0001, 5'd9,  1'b1, 32'h0000_0002);
  add_alu(ex_isa_pkg::ALU_SRL,  32'h8000_0000, 32'hFFFF_FFE1, 5'd10, 1'b1, 32'h4000_0000);
  add_alu(ex_isa_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_001F, 5'd11, 1'b1, 32'h0000_0001);
  add_alu(ex_isa_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_001F, 5'd12, 1'b1, 32'hFFFF_FFFF);
  add_alu(ex_isa_pkg::ALU_SRA,  32'h8000_0010, 32'h0000_0000, 5'd13, 1'b1, 32'h8000_0010);
  // Opposite signs, -1 vs 1
  add_alu(ex_isa_pkg::ALU_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 5'd14, 1'b1, 32'h0000_0001);
  add_alu(ex_isa_pkg::ALU_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 5'd15, 1'b1, 32'h0000_0000);
  // Branch compares, taken then not taken
  add_branch(ex_isa_pkg::ALU_BEQ,  32'h0000_0005, 32'h0000_0005, 32'h0000_1000, 1'b1);
  add_branch(ex_isa_pkg::ALU_BEQ,  32'h0000_0005, 32'h0000_0006, 32'h0000_1004, 1'b0);
  add_branch(ex_isa_pkg::ALU_BNE,  32'h0000_0005, 32'h0000_0006, 32'h0000_1008, 1'b1);
  add_branch(ex_isa_pkg::ALU_BNE,  32'h0000_0007, 32'h0000_0007, 32'h0000_100C, 1'b0);
  add_branch(ex_isa_pkg::ALU_BLT,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_2000, 1'b1);
  add_branch(ex_isa_pkg::ALU_BLT,  32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_2004, 1'b0);
  add_branch(ex_isa_pkg::ALU_BGE,  32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_2008, 1'b1);
  add_branch(ex_isa_pkg::ALU_BGE,  32'h8000_0000, 32'h0000_0000, 32'h0000_200C, 1'b0);
  add_branch(ex_isa_pkg::ALU_BLTU, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_3000, 1'b1);
  add_branch(ex_isa_pkg::ALU_BLTU, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_3004, 1'b0);
  add_branch(ex_isa_pkg::ALU_BGEU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_3008, 1'b1);
  add_branch(ex_isa_pkg::ALU_BGEU, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_300C, 1'b0);
  // Low word, then high words of signed, mixed and unsigned products
  add_mult(ex_isa_pkg::MULT_MUL,    32'hFFFF_FFFF, 32'h0000_0003, 5'd21, 32'hFFFF_FFFD);
  add_mult(ex_isa_pkg::MULT_MULH,   32'hFFFF_FFFF, 32'h0000_0003, 5'd22, 32'hFFFF_FFFF);
  add_mult(ex_isa_pkg::MULT_MULH,   32'h8000_0000, 32'h8000_0000, 5'd23, 32'h4000_0000);
  add_mult(ex_isa_pkg::MULT_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd24, 32'hFFFF_FFFF);
  add_mult(ex_isa_pkg::MULT_MULHSU, 32'h0000_0002, 32'h8000_0000, 5'd25, 32'h0000_0001);
  add_mult(ex_isa_pkg::MULT_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd26, 32'hFFFF_FFFE);
endtask

`endif

/* bench/ex_stage_tb.sv */
// Self-checking testbench for the execute stage that compiles with the sources in all.f
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

  ////////////////////////////////////////////////////////////////////////////
  // Signals and table
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD  = 10;
  // Inputs change this long after the rising edge
  localparam int DRIVE_DELAY = 1;

  logic                clk;
  logic                rst_n;
  logic                issue_valid;
  logic                issue_ready;
  ex_pipe_pkg::issue_t issue;
  logic                wb_valid;
  logic                wb_ready;
  ex_pipe_pkg::wb_t    wb;

  // Next free table slot while loading
  int                  vec_fill = 0;
  // Table indices issued and not yet seen at the output
  int                  sent_q[$];
  int                  rx_count = 0;
  // Output ready forced high for the latency checks
  logic                hold_ready = 1'b1;
  int unsigned         cycle_count = 0;

  `include "ex_stage_vectors.svh"

  // Table once under back-pressure plus the two latency ops
  localparam int TOTAL_RECORDS  = NUM_VEC + 2;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_RECORDS + 100;

  ex_stage_top i_ex_stage_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid),
    .issue_ready_o (issue_ready),
    .issue_i       (issue),
    .wb_valid_o    (wb_valid),
    .wb_ready_i    (wb_ready),
    .wb_o          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_alu(input ex_isa_pkg::alu_op_e op, input ex_isa_pkg::word_t a,
                         input ex_isa_pkg::word_t b, input ex_isa_pkg::reg_addr_t waddr,
                         input logic we, input ex_isa_pkg::word_t wdata);
    vec_issue[vec_fill]           = '0;
    vec_issue[vec_fill].unit      = ex_isa_pkg::UNIT_ALU;
    vec_issue[vec_fill].alu_op    = op;
    // Unused fields carry junk that must not leak out
    vec_issue[vec_fill].mult_op   = ex_isa_pkg::MULT_MULHU;
    vec_issue[vec_fill].operand_a = a;
    vec_issue[vec_fill].operand_b = b;
    vec_issue[vec_fill].operand_c = 32'hDEAD_BEEF;
    vec_issue[vec_fill].waddr     = waddr;
    vec_issue[vec_fill].we        = we;
    vec_wb[vec_fill]              = '0;
    vec_wb[vec_fill].we           = we;
    vec_wb[vec_fill].waddr        = waddr;
    vec_wb[vec_fill].wdata        = wdata;
    vec_fill++;
  endtask

  task automatic add_branch(input ex_isa_pkg::alu_op_e op, input ex_isa_pkg::word_t a,
                            input ex_isa_pkg::word_t b, input ex_isa_pkg::word_t target,
                            input logic taken);
    vec_issue[vec_fill]           = '0;
    vec_issue[vec_fill].unit      = ex_isa_pkg::UNIT_ALU;
    vec_issue[vec_fill].alu_op    = op;
    vec_issue[vec_fill].operand_a = a;
    vec_issue[vec_fill].operand_b = b;
    vec_issue[vec_fill].operand_c = target;
    // A write request that the branch has to drop
    vec_issue[vec_fill].waddr     = 5'd31;
    vec_issue[vec_fill].we        = 1'b1;
    vec_wb[vec_fill]              = '0;
    vec_wb[vec_fill].branch_taken = taken;
    vec_wb[vec_fill].jump_target  = target;
    vec_fill++;
  endtask

  task automatic add_mult(input ex_isa_pkg::mult_op_e op, input ex_isa_pkg::word_t a,
                          input ex_isa_pkg::word_t b, input ex_isa_pkg::reg_addr_t waddr,
                          input ex_isa_pkg::word_t wdata);
    vec_issue[vec_fill]           = '0;
    vec_issue[vec_fill].unit      = ex_isa_pkg::UNIT_MULT;
    // Branch encoding on the ALU field that the multiplier ignores
    vec_issue[vec_fill].alu_op    = ex_isa_pkg::ALU_BEQ;
    vec_issue[vec_fill].mult_op   = op;
    vec_issue[vec_fill].operand_a = a;
    vec_issue[vec_fill].operand_b = b;
    vec_issue[vec_fill].operand_c = 32'hDEAD_BEEF;
    vec_issue[vec_fill].waddr     = waddr;
    vec_issue[vec_fill].we        = 1'b1;
    vec_wb[vec_fill]              = '0;
    vec_wb[vec_fill].we           = 1'b1;
    vec_wb[vec_fill].waddr        = waddr;
    vec_wb[vec_fill].wdata        = wdata;
    vec_fill++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s exp=%b act=%b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  // Register write part of a record
  task automatic check_wb_write(input ex_pipe_pkg::wb_t exp, input ex_pipe_pkg::wb_t act,
                                input int idx);
    if (act.we !== exp.we) begin
      $display("MISMATCH t=%0t entry %0d wb_o.we exp=%b act=%b", $time, idx, exp.we, act.we);
      stop_on_error();
    end
    if (act.waddr !== exp.waddr) begin
      $display("MISMATCH t=%0t entry %0d wb_o.waddr exp=%0d act=%0d", $time, idx,
               exp.waddr, act.waddr);
      stop_on_error();
    end
    if (act.wdata !== exp.wdata) begin
      $display("MISMATCH t=%0t entry %0d wb_o.wdata exp=%h act=%h", $time, idx,
               exp.wdata, act.wdata);
      stop_on_error();
    end
  endtask

  // Branch decision part of a record
  task automatic check_branch(input ex_pipe_pkg::wb_t exp, input ex_pipe_pkg::wb_t act,
                              input int idx);
    if (act.branch_taken !== exp.branch_taken) begin
      $display("MISMATCH t=%0t entry %0d wb_o.branch_taken exp=%b act=%b", $time, idx,
               exp.branch_taken, act.branch_taken);
      stop_on_error();
    end
    if (act.jump_target !== exp.jump_target) begin
      $display("MISMATCH t=%0t entry %0d wb_o.jump_target exp=%h act=%h", $time, idx,
               exp.jump_target, act.jump_target);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  // Starts just after an edge and returns just after the accepting edge
  task automatic issue_op(input int idx);
    logic ready_seen;
    logic accepted;
    issue_valid = 1'b1;
    issue       = vec_issue[idx];
    sent_q.push_back(idx);
    accepted    = 1'b0;
    while (!accepted) begin
      // Registered ready holds here until the coming edge
      ready_seen = issue_ready;
      @(posedge clk);
      #(DRIVE_DELAY);
      accepted = ready_seen;
    end
    issue_valid = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  // Valid is due in cycle n when the handshake cycle counts as zero
  task automatic check_latency(input int cycles);
    for (int n = 1; n < cycles; n++) begin
      check_flag("wb_valid_o early", 1'b0, wb_valid);
      next_cycle();
    end
    check_flag("wb_valid_o on time", 1'b1, wb_valid);
  endtask

  task automatic wait_records(input int count);
    while (rx_count < count) begin
      next_cycle();
    end
  endtask

  initial begin : driver
    void'($urandom(32'h427));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    load_vectors();
    if (vec_fill != NUM_VEC) begin
      $display("Vector table holds %0d entries instead of %0d", vec_fill, NUM_VEC);
      stop_on_error();
    end
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    check_flag("wb_valid_o after reset", 1'b0, wb_valid);
    check_flag("issue_ready_o after reset", 1'b1, issue_ready);

    // ALU latency straight out of reset
    issue_op(ALU_LAT_IDX);
    check_latency(2);
    wait_records(1);

    // Whole table with issue gaps and output stalls
    hold_ready = 1'b0;
    for (int i = 0; i < NUM_VEC; i++) begin
      repeat ($urandom % 4) next_cycle();
      issue_op(i);
    end
    wait_records(NUM_VEC + 1);

    // Lone high product on an empty stage
    hold_ready = 1'b1;
    next_cycle();
    issue_op(MULH_LAT_IDX);
    check_latency(3);
    wait_records(TOTAL_RECORDS);
    next_cycle();

    // The last record has left and the stage holds nothing more
    if (wb_valid === 1'b0 && issue_ready === 1'b1) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Stage still busy after the last of %0d records", TOTAL_RECORDS);
      stop_on_error();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin : monitor
    int idx;
    wb_ready = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      next_cycle();
      wb_ready = hold_ready ? 1'b1 : (($urandom % 2) == 0);
      // Both high now means a transfer at the coming edge
      if (wb_valid && wb_ready) begin
        if (sent_q.size() == 0) begin
          $display("Writeback record at %0t with no operation outstanding", $time);
          stop_on_error();
        end
        idx = sent_q.pop_front();
        check_wb_write(vec_wb[idx], wb, idx);
        check_branch(vec_wb[idx], wb, idx);
        rx_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d records received",
               cycle_count, rx_count, TOTAL_RECORDS);
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

/* source/ex_stage_top.sv */
// Execute stage top, joins the issue buffer, execute step and writeback buffer
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top (
  input  logic                clk,
  input  logic                rst_n,

  // Issue from decode
  input  logic                issue_valid_i,
  output logic                issue_ready_o,
  input  ex_pipe_pkg::issue_t issue_i,

  // Writeback records in issue order
  output logic                wb_valid_o,
  input  logic                wb_ready_i,
  output ex_pipe_pkg::wb_t    wb_o
);

  // Input buffer to execute step
  logic                exec_in_valid;
  logic                exec_in_ready;
  ex_pipe_pkg::issue_t exec_in_data;
  // Execute step to output buffer
  logic                exec_out_valid;
  logic                exec_out_ready;
  ex_pipe_pkg::wb_t    exec_out_data;

  ex_skid_reg #(
    .payload_t (ex_pipe_pkg::issue_t)
  ) i_issue_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (issue_valid_i),
    .in_ready_o  (issue_ready_o),
    .in_data_i   (issue_i),
    .out_valid_o (exec_in_valid),
    .out_ready_i (exec_in_ready),
    .out_data_o  (exec_in_data)
  );

  ex_exec i_ex_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (exec_in_valid),
    .in_ready_o  (exec_in_ready),
    .in_data_i   (exec_in_data),
    .out_valid_o (exec_out_valid),
    .out_ready_i (exec_out_ready),
    .out_data_o  (exec_out_data)
  );

  // Output buffer decouples wb_ready_i from the execute step
  ex_skid_reg #(
    .payload_t (ex_pipe_pkg::wb_t)
  ) i_wb_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (exec_out_valid),
    .in_ready_o  (exec_out_ready),
    .in_data_i   (exec_out_data),
    .out_valid_o (wb_valid_o),
    .out_ready_i (wb_ready_i),
    .out_data_o  (wb_o)
  );

endmodule

`default_nettype wire

/* source/ex_exec.sv */
// Execute step between the buffers, dispatches to ALU or multiplier and forms writeback
`timescale 1ns/1ps
`default_nettype none

module ex_exec (
  input  logic                clk,
  input  logic                rst_n,

  // Issued operation from the input buffer
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  ex_pipe_pkg::issue_t in_data_i,

  // Writeback record towards the output buffer
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output ex_pipe_pkg::wb_t    out_data_o
);

  logic              is_alu;
  logic              is_mult;
  logic              is_br;
  logic              alu_taken;
  logic              mult_start;
  logic              mult_done;
  logic              out_xfer;
  ex_isa_pkg::word_t alu_result;
  ex_isa_pkg::word_t mult_result;

  assign is_alu  = (in_data_i.unit == ex_isa_pkg::UNIT_ALU);
  assign is_mult = (in_data_i.unit == ex_isa_pkg::UNIT_MULT);
  assign is_br   = is_alu & ex_isa_pkg::is_branch(in_data_i.alu_op);

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .operator_i  (in_data_i.alu_op),
    .operand_a_i (in_data_i.operand_a),
    .operand_b_i (in_data_i.operand_b),
    .result_o    (alu_result),
    .cmp_taken_o (alu_taken)
  );

  // Dropped in the transfer cycle so the phase returns to idle
  assign mult_start = in_valid_i & is_mult & ~out_xfer;

  ex_mult i_ex_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (mult_start),
    .operator_i  (in_data_i.mult_op),
    .operand_a_i (in_data_i.operand_a),
    .operand_b_i (in_data_i.operand_b),
    .result_o    (mult_result),
    .done_o      (mult_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // ALU always ready, multiplier when its result is there
  assign out_valid_o = in_valid_i & (is_alu | mult_done);
  assign out_xfer    = out_valid_o & out_ready_i;
  // Op leaves the input only together with its result
  assign in_ready_o  = out_xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Writeback record
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_data_o = '0;
    if (is_br) begin
      // Branch decision only, no register write
      out_data_o.branch_taken = alu_taken;
      out_data_o.jump_target  = in_data_i.operand_c;
    end else begin
      out_data_o.we    = in_data_i.we;
      out_data_o.waddr = in_data_i.waddr;
      out_data_o.wdata = is_mult ? mult_result : alu_result;
    end
  end

endmodule

`default_nettype wire

/* source/ex_mult.sv */
// Multiplier with a single-cycle low product and a two-cycle high product
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,
  // Operation held and not yet handed on
  input  logic                 start_i,
  input  ex_isa_pkg::mult_op_e operator_i,
  input  ex_isa_pkg::word_t    operand_a_i,
  input  ex_isa_pkg::word_t    operand_b_i,
  output ex_isa_pkg::word_t    result_o,
  output logic                 done_o
);

  logic                                signed_a;
  logic                                signed_b;
  logic                                high_op;
  // Operands widened by one bit so one signed multiplier covers all modes
  logic [ex_isa_pkg::XLEN:0]           mul_a;
  logic [ex_isa_pkg::XLEN:0]           mul_b;
  logic signed [2*ex_isa_pkg::XLEN+1:0] prod_full;
  // Registered 64-bit product for the high word
  logic [2*ex_isa_pkg::XLEN-1:0]       prod_q;
  // Second cycle of a high-word op
  logic                                phase_q;

  ////////////////////////////////////////////////////////////////////////////
  // Sign handling
  ////////////////////////////////////////////////////////////////////////////

  // MULH signed x signed, MULHSU signed x unsigned, MULHU unsigned
  assign signed_a = operator_i inside {ex_isa_pkg::MULT_MULH, ex_isa_pkg::MULT_MULHSU};
  assign signed_b = (operator_i == ex_isa_pkg::MULT_MULH);
  assign high_op  = (operator_i != ex_isa_pkg::MULT_MUL);

  assign mul_a = {signed_a & operand_a_i[ex_isa_pkg::XLEN-1], operand_a_i};
  assign mul_b = {signed_b & operand_b_i[ex_isa_pkg::XLEN-1], operand_b_i};

  // Low word is the same for every signedness
  assign prod_full = $signed(mul_a) * $signed(mul_b);

  ////////////////////////////////////////////////////////////////////////////
  // Phase tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= 1'b0;
    end else if (phase_q) begin
      // Held until the result has been taken
      phase_q <= start_i;
    end else begin
      phase_q <= start_i & high_op;
    end
  end

  // Product captured in the first cycle
  always_ff @(posedge clk) begin
    if (start_i & high_op & ~phase_q) begin
      prod_q <= prod_full[2*ex_isa_pkg::XLEN-1:0];
    end
  end

  // MUL answers at once, the high group one cycle later
  assign done_o   = phase_q | ~high_op;
  assign result_o = phase_q ? prod_q[2*ex_isa_pkg::XLEN-1:ex_isa_pkg::XLEN]
                            : prod_full[ex_isa_pkg::XLEN-1:0];

endmodule

`default_nettype wire

/* source/ex_alu.sv */
// Integer ALU with add/sub, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_isa_pkg::alu_op_e operator_i,
  input  ex_isa_pkg::word_t   operand_a_i,
  input  ex_isa_pkg::word_t   operand_b_i,
  output ex_isa_pkg::word_t   result_o,
  output logic                cmp_taken_o
);

  // Shift amount from the low bits of operand b
  logic [ex_isa_pkg::SHAMT_W-1:0] shamt;
  // Signed compare for SLT, BLT and BGE
  logic                           cmp_signed;
  // One extra bit keeps the borrow or sign of the difference
  logic [ex_isa_pkg::XLEN:0]      cmp_a;
  logic [ex_isa_pkg::XLEN:0]      cmp_b;
  logic [ex_isa_pkg::XLEN:0]      cmp_diff;
  logic                           less;
  logic                           equal;

  assign shamt = operand_b_i[ex_isa_pkg::SHAMT_W-1:0];

  assign cmp_signed = operator_i inside {ex_isa_pkg::ALU_SLT,
                                         ex_isa_pkg::ALU_BLT,
                                         ex_isa_pkg::ALU_BGE};

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  // Sign or zero extension by compare mode
  assign cmp_a    = {cmp_signed & operand_a_i[ex_isa_pkg::XLEN-1], operand_a_i};
  assign cmp_b    = {cmp_signed & operand_b_i[ex_isa_pkg::XLEN-1], operand_b_i};
  assign cmp_diff = cmp_a - cmp_b;
  // MSB of the widened difference is the less-than flag
  assign less     = cmp_diff[ex_isa_pkg::XLEN];
  assign equal    = (operand_a_i == operand_b_i);

  always_comb begin
    unique case (operator_i)
      ex_isa_pkg::ALU_BEQ:  cmp_taken_o = equal;
      ex_isa_pkg::ALU_BNE:  cmp_taken_o = ~equal;
      ex_isa_pkg::ALU_BLT,
      ex_isa_pkg::ALU_BLTU: cmp_taken_o = less;
      ex_isa_pkg::ALU_BGE,
      ex_isa_pkg::ALU_BGEU: cmp_taken_o = ~less;
      // Not a branch
      default:              cmp_taken_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ex_isa_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ex_isa_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ex_isa_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_isa_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_isa_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_isa_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_isa_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift fills with the sign bit
      ex_isa_pkg::ALU_SRA:  result_o = ex_isa_pkg::word_t'($signed(operand_a_i) >>> shamt);
      ex_isa_pkg::ALU_SLT,
      ex_isa_pkg::ALU_SLTU: result_o = {{(ex_isa_pkg::XLEN-1){1'b0}}, less};
      // Branch compares write nothing
      default:              result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/ex_skid_reg.sv */
// Two-entry valid/ready buffer for any payload type, placed at the stage input and output
`timescale 1ns/1ps
`default_nettype none

module ex_skid_reg #(
  // Record type carried through the buffer
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  // Main entry drives the output
  logic     main_valid_q;
  payload_t main_data_q;
  // Skid entry catches one record while the output stalls
  logic     skid_valid_q;
  payload_t skid_data_q;

  logic     in_xfer;
  logic     main_free;

  // Ready straight from a flop, never from out_ready_i
  assign in_ready_o  = ~skid_valid_q;
  assign out_valid_o = main_valid_q;
  assign out_data_o  = main_data_q;

  assign in_xfer   = in_valid_i & in_ready_o;
  // Main entry can take a new record this cycle
  assign main_free = ~main_valid_q | out_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      // Skid entry drains first to keep order
      if (skid_valid_q) begin
        main_valid_q <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        main_valid_q <= in_xfer;
      end
    end else if (in_xfer) begin
      // Output stalled, park the incoming record
      skid_valid_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid_q) begin
        main_data_q <= skid_data_q;
      end else if (in_xfer) begin
        main_data_q <= in_data_i;
      end
    end else if (in_xfer) begin
      skid_data_q <= in_data_i;
    end
  end

endmodule

`default_nettype wire

/* source/ex_pipe_pkg.sv */
// Packed records passed between the issue side, the execute step and writeback
`default_nettype none

package ex_pipe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Issue record
  ////////////////////////////////////////////////////////////////////////////

  // One operation from decode, 109 bits
  typedef struct packed {
    // Selects ALU or multiplier
    ex_isa_pkg::unit_e     unit;
    // Only the field of the selected unit matters
    ex_isa_pkg::alu_op_e   alu_op;
    ex_isa_pkg::mult_op_e  mult_op;
    ex_isa_pkg::word_t     operand_a;
    ex_isa_pkg::word_t     operand_b;
    // Jump target for branch compares
    ex_isa_pkg::word_t     operand_c;
    // Destination register
    ex_isa_pkg::reg_addr_t waddr;
    logic                  we;
  } issue_t;

  ////////////////////////////////////////////////////////////////////////////
  // Writeback record
  ////////////////////////////////////////////////////////////////////////////

  // Register write or branch decision
  typedef struct packed {
    logic                  we;
    ex_isa_pkg::reg_addr_t waddr;
    ex_isa_pkg::word_t     wdata;
    logic                  branch_taken;
    ex_isa_pkg::word_t     jump_target;
  } wb_t;

endpackage

`default_nettype wire

/* source/ex_isa_pkg.sv */
// Data widths and operator encodings shared by the ALU, multiplier and execute step
`default_nettype none

package ex_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // Shift amount field taken from operand b
  localparam int unsigned SHAMT_W    = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // Target functional unit
  typedef enum logic [0:0] {
    UNIT_ALU  = 1'b0,
    UNIT_MULT = 1'b1
  } unit_e;

  // ALU operators, branch compares sit in the upper half
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_BEQ  = 4'd10,
    ALU_BNE  = 4'd11,
    ALU_BLT  = 4'd12,
    ALU_BGE  = 4'd13,
    ALU_BLTU = 4'd14,
    ALU_BGEU = 4'd15
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

  // True for the conditional branch compares
  function automatic logic is_branch(alu_op_e op);
    return op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
  endfunction

endpackage

`default_nettype wire
